//--- rtl/core_pkg.sv
package core_pkg;

    localparam int XLEN    = 32;
    localparam int SHAMT_W = $clog2(XLEN);

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // Operation groups sit in the two top bits. Plain ALU codes only need bit 4 clear.
    localparam logic [1:0] BRANCH_PRFX = 2'b10;
    localparam logic [1:0] J_PRFX      = 2'b11;

    typedef enum logic [4:0] {
        ALU_ADD   = 5'b00000,
        ALU_SUB   = 5'b00001,
        ALU_SLL   = 5'b00010,
        ALU_SLT   = 5'b00011,
        ALU_SLTU  = 5'b00100,
        ALU_XOR   = 5'b00101,
        ALU_SRL   = 5'b00110,
        ALU_SRA   = 5'b00111,
        ALU_OR    = 5'b01000,
        ALU_AND   = 5'b01001,
        ALU_LUI   = 5'b01010,
        ALU_AUIPC = 5'b01011,
        ALU_BEQ   = 5'b10000,  // Low bits follow funct3 of the branch.
        ALU_BNE   = 5'b10001,
        ALU_BLT   = 5'b10100,
        ALU_BGE   = 5'b10101,
        ALU_BLTU  = 5'b10110,
        ALU_BGEU  = 5'b10111,
        ALU_JAL   = 5'b11000,
        ALU_JALR  = 5'b11001
    } alu_op_e;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_JALR    = 3'b000;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB and SRA/SRAI.

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word, seen through each encoding format.
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

endpackage

//--- rtl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
    import core_pkg::*;
(
    input  instr_u    instr_i,
    output alu_op_e   op_o,
    output word_t     imm_o,
    output logic      rs2_is_imm_o,
    output reg_addr_t rd_addr_o,
    output logic      rd_we_o,
    output logic      illegal_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_base;
    logic       f7_alt;
    word_t      imm_i_ext;
    word_t      imm_b_ext;
    word_t      imm_u_ext;
    word_t      imm_j_ext;

    assign opcode  = instr_i.r.opcode;
    assign funct3  = instr_i.r.funct3;
    assign funct7  = instr_i.r.funct7;  // For shift immediates this is imm[11:5].
    assign f7_base = (funct7 == F7_BASE);
    assign f7_alt  = (funct7 == F7_ALT);

    assign imm_i_ext = {{(XLEN-12){instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};
    assign imm_b_ext = {{(XLEN-12){instr_i.b.imm_12}}, instr_i.b.imm_11,
                        instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
    assign imm_u_ext = {instr_i.u.imm_31_12, 12'b0};
    assign imm_j_ext = {{(XLEN-20){instr_i.j.imm_20}}, instr_i.j.imm_19_12,
                        instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};

    assign rd_addr_o = instr_i.r.rd;

    always_comb begin
        op_o         = ALU_ADD;
        imm_o        = '0;
        rs2_is_imm_o = 1'b0;
        rd_we_o      = 1'b0;
        illegal_o    = 1'b0;
        case (opcode)
            OPC_OP: begin
                rd_we_o = 1'b1;
                case (funct3)
                    F3_ADD_SUB: op_o = f7_alt ? ALU_SUB : ALU_ADD;
                    F3_SLL:     op_o = ALU_SLL;
                    F3_SLT:     op_o = ALU_SLT;
                    F3_SLTU:    op_o = ALU_SLTU;
                    F3_XOR:     op_o = ALU_XOR;
                    F3_SRL_SRA: op_o = f7_alt ? ALU_SRA : ALU_SRL;
                    F3_OR:      op_o = ALU_OR;
                    default:    op_o = ALU_AND;
                endcase
                // Only ADD/SUB and SRL/SRA accept the alternate funct7.
                if (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA) begin
                    illegal_o = !(f7_base || f7_alt);
                end else begin
                    illegal_o = !f7_base;
                end
            end
            OPC_OP_IMM: begin
                imm_o        = imm_i_ext;
                rs2_is_imm_o = 1'b1;
                rd_we_o      = 1'b1;
                case (funct3)
                    F3_ADD_SUB: op_o = ALU_ADD;  // There is no SUBI.
                    F3_SLL:     op_o = ALU_SLL;
                    F3_SLT:     op_o = ALU_SLT;
                    F3_SLTU:    op_o = ALU_SLTU;
                    F3_XOR:     op_o = ALU_XOR;
                    F3_SRL_SRA: op_o = f7_alt ? ALU_SRA : ALU_SRL;
                    F3_OR:      op_o = ALU_OR;
                    default:    op_o = ALU_AND;
                endcase
                if (funct3 == F3_SLL) begin
                    illegal_o = !f7_base;
                end else if (funct3 == F3_SRL_SRA) begin
                    illegal_o = !(f7_base || f7_alt);
                end
            end
            OPC_LUI: begin
                op_o    = ALU_LUI;
                imm_o   = imm_u_ext;
                rd_we_o = 1'b1;
            end
            OPC_AUIPC: begin
                op_o    = ALU_AUIPC;
                imm_o   = imm_u_ext;
                rd_we_o = 1'b1;
            end
            OPC_JAL: begin
                op_o    = ALU_JAL;
                imm_o   = imm_j_ext;
                rd_we_o = 1'b1;
            end
            OPC_JALR: begin
                op_o      = ALU_JALR;
                imm_o     = imm_i_ext;
                rd_we_o   = 1'b1;
                illegal_o = (funct3 != F3_JALR);
            end
            OPC_BRANCH: begin
                imm_o = imm_b_ext;
                case (funct3)
                    F3_BEQ:  op_o = ALU_BEQ;
                    F3_BNE:  op_o = ALU_BNE;
                    F3_BLT:  op_o = ALU_BLT;
                    F3_BGE:  op_o = ALU_BGE;
                    F3_BLTU: op_o = ALU_BLTU;
                    F3_BGEU: op_o = ALU_BGEU;
                    default: illegal_o = 1'b1;
                endcase
            end
            default: illegal_o = 1'b1;
        endcase
        if (illegal_o) begin
            rd_we_o = 1'b0;
        end
    end

endmodule

//--- rtl/int_alu.sv
`timescale 1ns/1ps

module int_alu
    import core_pkg::*;
(
    input  alu_op_e op_i,
    input  word_t   pc_i,
    input  word_t   rs1_i,
    input  word_t   rs2_i,
    input  word_t   imm_i,
    input  logic    rs2_is_imm_i,
    output word_t   result_o
);

    word_t              op_b;
    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    assign op_b        = rs2_is_imm_i ? imm_i : rs2_i;
    assign shamt       = op_b[SHAMT_W-1:0];  // Upper bits of the shift amount are ignored.
    assign lt_signed   = $signed(rs1_i) < $signed(op_b);
    assign lt_unsigned = rs1_i < op_b;

    always_comb begin
        case (op_i)
            ALU_ADD:   result_o = rs1_i + op_b;
            ALU_SUB:   result_o = rs1_i - op_b;
            ALU_SLL:   result_o = rs1_i << shamt;
            ALU_SLT:   result_o = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:  result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:   result_o = rs1_i ^ op_b;
            ALU_SRL:   result_o = rs1_i >> shamt;
            ALU_SRA:   result_o = word_t'($signed(rs1_i) >>> shamt);
            ALU_OR:    result_o = rs1_i | op_b;
            ALU_AND:   result_o = rs1_i & op_b;
            ALU_LUI:   result_o = imm_i;
            ALU_AUIPC: result_o = pc_i + imm_i;
            // Branches and jumps are resolved in the branch unit.
            default:   result_o = '0;
        endcase
    end

endmodule

//--- rtl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit
    import core_pkg::*;
(
    input  alu_op_e op_i,
    input  word_t   pc_i,
    input  word_t   rs1_i,
    input  word_t   rs2_i,
    input  word_t   imm_i,
    output logic    taken_o,
    output word_t   target_o,
    output word_t   link_o
);

    word_t pc_rel;
    word_t reg_rel;

    assign pc_rel  = pc_i + imm_i;
    assign reg_rel = rs1_i + imm_i;

    always_comb begin
        taken_o  = 1'b0;
        target_o = '0;
        link_o   = '0;
        if (op_i[4:3] == BRANCH_PRFX) begin
            target_o = pc_rel;
            case (op_i)
                ALU_BEQ:  taken_o = (rs1_i == rs2_i);
                ALU_BNE:  taken_o = (rs1_i != rs2_i);
                ALU_BLT:  taken_o = $signed(rs1_i) < $signed(rs2_i);
                ALU_BGE:  taken_o = $signed(rs1_i) >= $signed(rs2_i);
                ALU_BLTU: taken_o = rs1_i < rs2_i;
                ALU_BGEU: taken_o = rs1_i >= rs2_i;
                default:  taken_o = 1'b0;
            endcase
        end else if (op_i[4:3] == J_PRFX) begin
            taken_o = 1'b1;  // Jumps never fall through.
            link_o  = pc_i + 32'd4;
            if (op_i == ALU_JALR) begin
                target_o = {reg_rel[XLEN-1:1], 1'b0};
            end else begin
                target_o = pc_rel;
            end
        end
    end

    // The decoder always builds an even J immediate, so this holds while the pc is aligned.
    always_comb begin
        if (taken_o && op_i == ALU_JAL) begin
            assert final (target_o[0] == 1'b0)
            else $error("JAL target %h has bit 0 set", target_o);
        end
    end

endmodule

//--- rtl/ex_result_stage.sv
`timescale 1ns/1ps

module ex_result_stage
    import core_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      in_valid_i,
    input  logic      out_ready_i,
    input  alu_op_e   op_i,
    input  reg_addr_t rd_addr_i,
    input  logic      rd_we_i,
    input  logic      illegal_i,
    input  logic      taken_i,
    input  word_t     alu_result_i,
    input  word_t     link_i,
    input  word_t     target_i,
    output logic      in_ready_o,
    output logic      out_valid_o,
    output reg_addr_t out_rd_addr_o,
    output logic      out_rd_we_o,
    output word_t     out_rd_data_o,
    output logic      out_flush_o,
    output word_t     out_target_o,
    output logic      out_illegal_o
);

    logic  is_branch;
    logic  is_jump;
    logic  wb_we;
    logic  flush;
    word_t wb_data;
    logic  accept;

    assign is_branch = (op_i[4:3] == BRANCH_PRFX);
    assign is_jump   = (op_i[4:3] == J_PRFX);

    assign wb_data = is_jump ? link_i : alu_result_i;
    assign wb_we   = rd_we_i && !illegal_i && !is_branch && (rd_addr_i != '0);
    assign flush   = taken_i && (is_branch || is_jump) && !illegal_i;

    // The register may refill in the same cycle it drains.
    assign in_ready_o = !out_valid_o || out_ready_i;
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            out_valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            out_rd_addr_o <= rd_addr_i;
            out_rd_we_o   <= wb_we;
            out_rd_data_o <= wb_data;
            out_flush_o   <= flush;
            out_target_o  <= target_i;
            out_illegal_o <= illegal_i;
        end
    end

    // A stalled beat must not change until the consumer takes it.
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable({out_rd_addr_o, out_rd_we_o,
            out_rd_data_o, out_flush_o, out_target_o, out_illegal_o}))
    else $error("Output beat changed while stalled");

    assert property (@(posedge clk_i) $rose(rst_n_i) |-> !out_valid_o)
    else $error("out_valid_o high right after reset");

endmodule

//--- rtl/ex_top.sv
`timescale 1ns/1ps

module ex_top
    import core_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      in_valid_i,
    output logic      in_ready_o,
    input  instr_u    in_instr_i,
    input  word_t     in_pc_i,
    input  word_t     in_rs1_data_i,
    input  word_t     in_rs2_data_i,
    output logic      out_valid_o,
    input  logic      out_ready_i,
    output reg_addr_t out_rd_addr_o,
    output logic      out_rd_we_o,
    output word_t     out_rd_data_o,
    output logic      out_flush_o,
    output word_t     out_target_o,
    output logic      out_illegal_o
);

    alu_op_e   op;
    word_t     imm;
    logic      rs2_is_imm;
    reg_addr_t rd_addr;
    logic      rd_we;
    logic      illegal;
    word_t     alu_result;
    logic      taken;
    word_t     target;
    word_t     link;

    instr_decoder i_decoder (
        .instr_i      (in_instr_i),
        .op_o         (op),
        .imm_o        (imm),
        .rs2_is_imm_o (rs2_is_imm),
        .rd_addr_o    (rd_addr),
        .rd_we_o      (rd_we),
        .illegal_o    (illegal)
    );

    // ALU and branch unit see the same decoded beat.
    int_alu i_alu (
        .op_i         (op),
        .pc_i         (in_pc_i),
        .rs1_i        (in_rs1_data_i),
        .rs2_i        (in_rs2_data_i),
        .imm_i        (imm),
        .rs2_is_imm_i (rs2_is_imm),
        .result_o     (alu_result)
    );

    branch_unit i_branch (
        .op_i     (op),
        .pc_i     (in_pc_i),
        .rs1_i    (in_rs1_data_i),
        .rs2_i    (in_rs2_data_i),
        .imm_i    (imm),
        .taken_o  (taken),
        .target_o (target),
        .link_o   (link)
    );

    ex_result_stage i_result (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .in_valid_i    (in_valid_i),
        .out_ready_i   (out_ready_i),
        .op_i          (op),
        .rd_addr_i     (rd_addr),
        .rd_we_i       (rd_we),
        .illegal_i     (illegal),
        .taken_i       (taken),
        .alu_result_i  (alu_result),
        .link_i        (link),
        .target_i      (target),
        .in_ready_o    (in_ready_o),
        .out_valid_o   (out_valid_o),
        .out_rd_addr_o (out_rd_addr_o),
        .out_rd_we_o   (out_rd_we_o),
        .out_rd_data_o (out_rd_data_o),
        .out_flush_o   (out_flush_o),
        .out_target_o  (out_target_o),
        .out_illegal_o (out_illegal_o)
    );

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;  // Released on an edge like any other input.
    end

endmodule

//--- test/tb_ex_top.sv
`timescale 1ns/1ps

module tb_ex_top
    import core_pkg::*;
();

    localparam int     CLK_PERIOD_NS = 100;
    localparam int     RESET_CYCLES  = 16;
    localparam int     NUM_TESTS     = 2000;
    localparam int     DRAIN_CYCLES  = 50;
    localparam longint TIMEOUT_NS    = longint'(RESET_CYCLES + NUM_TESTS * 20) * CLK_PERIOD_NS;
    localparam int     SEED          = 32'h95aa_9d25;

    typedef struct packed {
        reg_addr_t rd;
        logic      we;
        word_t     data;
        logic      flush;
        word_t     target;
        logic      illegal;
    } beat_t;

    logic      clk;
    logic      rst_n;
    logic      in_valid_i;
    logic      in_ready_o;
    instr_u    in_instr_i;
    word_t     in_pc_i;
    word_t     in_rs1_data_i;
    word_t     in_rs2_data_i;
    logic      out_valid_o;
    logic      out_ready_i;
    reg_addr_t out_rd_addr_o;
    logic      out_rd_we_o;
    word_t     out_rd_data_o;
    logic      out_flush_o;
    word_t     out_target_o;
    logic      out_illegal_o;

    int    seed    = SEED;
    int    bp_seed = SEED ^ 32'h1;  // Own stream so back-pressure does not shift the stimulus.
    beat_t exp_q[$];
    int    acc_q[$];  // Cycle in which each queued beat was accepted.
    int    cycle     = 0;
    int    n_errors  = 0;
    int    n_checked = 0;
    logic  head_seen = 1'b0;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) i_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    ex_top i_dut (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .in_instr_i    (in_instr_i),
        .in_pc_i       (in_pc_i),
        .in_rs1_data_i (in_rs1_data_i),
        .in_rs2_data_i (in_rs2_data_i),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .out_rd_addr_o (out_rd_addr_o),
        .out_rd_we_o   (out_rd_we_o),
        .out_rd_data_o (out_rd_data_o),
        .out_flush_o   (out_flush_o),
        .out_target_o  (out_target_o),
        .out_illegal_o (out_illegal_o)
    );

    function automatic word_t rand_word();
        return word_t'($random(seed));
    endfunction

    function automatic int rand_below(input int n);
        return int'(rand_word() % word_t'(n));
    endfunction

    // Corner values make the equal and sign-boundary compares frequent.
    function automatic word_t pick_operand();
        case (rand_below(8))
            0: return 32'h0000_0000;
            1: return 32'h8000_0000;
            2: return 32'h7fff_ffff;
            3: return 32'hffff_ffff;
            default: return rand_word();
        endcase
    endfunction

    function automatic logic [6:0] pick_funct7();
        case (rand_below(4))
            0, 1: return F7_BASE;
            2: return F7_ALT;
            default: return 7'(rand_word());
        endcase
    endfunction

    function automatic instr_u make_instr();
        instr_u w;
        w = instr_u'(rand_word());
        case (rand_below(9))
            0: begin
                w.r.opcode = OPC_OP;
                w.r.funct7 = pick_funct7();
            end
            1: begin
                w.i.opcode = OPC_OP_IMM;
                if (w.i.funct3 == F3_SLL || w.i.funct3 == F3_SRL_SRA) begin
                    w.r.funct7 = pick_funct7();
                end
            end
            2: w.u.opcode = OPC_LUI;
            3: w.u.opcode = OPC_AUIPC;
            4: w.j.opcode = OPC_JAL;
            5: begin
                w.i.opcode = OPC_JALR;
                if (rand_below(8) != 0) begin
                    w.i.funct3 = F3_JALR;
                end
            end
            6, 7: w.b.opcode = OPC_BRANCH;
            default: ;  // Raw random word, nearly always an unknown opcode.
        endcase
        if (rand_below(8) == 0) begin
            w.r.rd = '0;
        end
        return w;
    endfunction

    // Expected beat from the RV32I rules, decoded from the raw bits.
    function automatic beat_t ref_model(input instr_u w, input word_t pc, input word_t a,
                                        input word_t b);
        beat_t       e;
        logic [31:0] x;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        alt;
        logic        is_imm;
        word_t       imm_i;
        word_t       imm_b;
        word_t       imm_u;
        word_t       imm_j;
        word_t       op2;
        x      = w;
        f3     = x[14:12];
        f7     = x[31:25];
        alt    = (f7 == 7'b0100000);
        is_imm = (x[6:0] == OPC_OP_IMM);
        imm_i  = {{20{x[31]}}, x[31:20]};
        imm_b  = {{20{x[31]}}, x[7], x[30:25], x[11:8], 1'b0};
        imm_u  = {x[31:12], 12'b0};
        imm_j  = {{12{x[31]}}, x[19:12], x[20], x[30:21], 1'b0};
        op2    = is_imm ? imm_i : b;
        e      = '0;
        e.rd   = x[11:7];
        case (x[6:0])
            OPC_OP, OPC_OP_IMM: begin
                e.we = 1'b1;
                case (f3)
                    3'b000:  e.data = (alt && !is_imm) ? a - op2 : a + op2;
                    3'b001:  e.data = a << op2[4:0];
                    3'b010:  e.data = {31'b0, $signed(a) < $signed(op2)};
                    3'b011:  e.data = {31'b0, a < op2};
                    3'b100:  e.data = a ^ op2;
                    3'b101:  e.data = alt ? word_t'($signed(a) >>> op2[4:0]) : a >> op2[4:0];
                    3'b110:  e.data = a | op2;
                    default: e.data = a & op2;
                endcase
                if (!is_imm && (f3 == 3'b000 || f3 == 3'b101)) begin
                    e.illegal = (f7 != 7'd0) && !alt;
                end else if (!is_imm || f3 == 3'b001) begin
                    e.illegal = (f7 != 7'd0);
                end else if (f3 == 3'b101) begin
                    e.illegal = (f7 != 7'd0) && !alt;  // SRAI keeps the SRA pattern.
                end
            end
            OPC_LUI: begin
                e.we   = 1'b1;
                e.data = imm_u;
            end
            OPC_AUIPC: begin
                e.we   = 1'b1;
                e.data = pc + imm_u;
            end
            OPC_JAL: begin
                e.we     = 1'b1;
                e.data   = pc + 32'd4;
                e.flush  = 1'b1;
                e.target = pc + imm_j;
            end
            OPC_JALR: begin
                if (f3 != 3'b000) begin
                    e.illegal = 1'b1;
                end else begin
                    e.we     = 1'b1;
                    e.data   = pc + 32'd4;
                    e.flush  = 1'b1;
                    e.target = (a + imm_i) & ~32'h1;
                end
            end
            OPC_BRANCH: begin
                e.target = pc + imm_b;
                case (f3)
                    3'b000:  e.flush = (a == b);
                    3'b001:  e.flush = (a != b);
                    3'b100:  e.flush = $signed(a) < $signed(b);
                    3'b101:  e.flush = $signed(a) >= $signed(b);
                    3'b110:  e.flush = a < b;
                    3'b111:  e.flush = a >= b;
                    default: e.illegal = 1'b1;
                endcase
            end
            default: e.illegal = 1'b1;
        endcase
        if (e.illegal || e.rd == 5'd0) begin
            e.we = 1'b0;
        end
        return e;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            n_errors++;
            $display("[FAIL] time %0t: %s = %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t want);
        if (got !== want) begin
            n_errors++;
            $display("[FAIL] time %0t: %s = %0d, expected %0d", $time, name, got, want);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            n_errors++;
            $display("[FAIL] time %0t: %s = %b, expected %b", $time, name, got, want);
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin : backpressure
        out_ready_i = 1'b0;
        forever begin
            @(posedge clk);
            out_ready_i <= (word_t'($random(bp_seed)) % 4) != 0;  // Ready three cycles in four.
        end
    end

    always @(posedge clk) begin : compare
        beat_t want;
        if (rst_n && out_valid_o) begin
            if (exp_q.size() == 0) begin
                if (out_ready_i) begin
                    n_errors++;
                    $display("Output beat at time %0t has no matching input beat", $time);
                end
            end else begin
                if (!head_seen) begin
                    if (cycle != acc_q[0] + 1) begin
                        n_errors++;
                        $display("Beat accepted in cycle %0d first showed up in cycle %0d",
                                 acc_q[0], cycle);
                    end
                    head_seen = 1'b1;
                end
                if (out_ready_i) begin
                    want = exp_q.pop_front();
                    acc_q.delete(0);
                    check_bit("out_rd_we_o", out_rd_we_o, want.we);
                    if (want.we) begin
                        check_addr("out_rd_addr_o", out_rd_addr_o, want.rd);
                        check_word("out_rd_data_o", out_rd_data_o, want.data);
                    end
                    check_bit("out_flush_o", out_flush_o, want.flush);
                    if (want.flush) begin
                        check_word("out_target_o", out_target_o, want.target);
                    end
                    check_bit("out_illegal_o", out_illegal_o, want.illegal);
                    n_checked++;
                    head_seen = 1'b0;
                end
            end
        end
    end

    initial begin : stimulus
        instr_u w;
        word_t  pc;
        word_t  a;
        word_t  b;
        int     n;
        int     drain;
        in_valid_i    = 1'b0;
        in_instr_i    = '0;
        in_pc_i       = '0;
        in_rs1_data_i = '0;
        in_rs2_data_i = '0;
        @(posedge rst_n);
        @(posedge clk);
        check_bit("out_valid_o", out_valid_o, 1'b0);
        for (n = 0; n < NUM_TESTS; n++) begin
            if (rand_below(8) == 0) begin
                in_valid_i <= 1'b0;
                @(posedge clk);
            end
            w  = make_instr();
            pc = rand_word() & 32'hffff_fffc;
            a  = pick_operand();
            b  = (rand_below(6) == 0) ? a : pick_operand();
            in_valid_i    <= 1'b1;
            in_instr_i    <= w;
            in_pc_i       <= pc;
            in_rs1_data_i <= a;
            in_rs2_data_i <= b;
            do @(posedge clk); while (!in_ready_o);
            exp_q.push_back(ref_model(w, pc, a, b));
            acc_q.push_back(cycle);
        end
        in_valid_i <= 1'b0;
        drain = 0;
        while (exp_q.size() != 0 && drain < DRAIN_CYCLES) begin
            @(posedge clk);
            drain++;
        end
        if (exp_q.size() != 0) begin
            n_errors++;
            $display("%0d accepted beats never reached the output", exp_q.size());
        end
        repeat (4) @(posedge clk);  // Room for a duplicated beat to show up.
        $display("Checked %0d of %0d beats, %0d errors", n_checked, NUM_TESTS, n_errors);
        if (n_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, %0d of %0d beats checked, %0d errors",
                 TIMEOUT_NS, n_checked, NUM_TESTS, n_errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- list.f
rtl/core_pkg.sv
rtl/instr_decoder.sv
rtl/int_alu.sv
rtl/branch_unit.sv
rtl/ex_result_stage.sv
rtl/ex_top.sv
test/tb_clock_gen.sv
test/tb_ex_top.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_ex_top
FILELIST   := list.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
FAIL_MSG   := Finished with errors
PASS_MSG   := Finished with no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
